//--- rv_platform.f
platform_pkg.sv
mem_bus_if.sv
bus_decoder.sv
data_ram.sv
rtc_timer.sv
plic.sv
button_periph.sv
rv_platform.sv
platform_checker.sv
tb_platform.sv

//--- run_sim.sh
#!/bin/sh
# build and run the platform testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module tb_platform -f rv_platform.f -o sim_platform \
    && ./obj_dir/sim_platform > sim.log 2>&1 \
    || echo "build or run ended with an error"
cat sim.log 2>/dev/null
grep -q ">>> PASS" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

//--- tb_platform.sv
`timescale 1ns/1ns

module tb_platform
    import platform_pkg::*;
();
    logic               clk;
    logic               reset_i;
    logic               bus_en;
    logic [BE_W-1:0]    bus_we;
    logic [ADDR_W-1:0]  bus_addr;
    logic [DATA_W-1:0]  bus_wdata;
    logic [DATA_W-1:0]  bus_rdata;
    logic [IRQ_CNT-1:0] button;
    logic               mti;
    logic               mei;

    logic [31:0] lcg_state = 32'd1537;
    int          cyc = 0;           // rising edges so far
    int          last_rd_cyc;       // cycle count when the last read was issued
    int          err_mark;

    rv_platform u_dut (
        .clk         (clk),
        .reset_i     (reset_i),
        .bus_en_i    (bus_en),
        .bus_we_i    (bus_we),
        .bus_addr_i  (bus_addr),
        .bus_wdata_i (bus_wdata),
        .bus_rdata_o (bus_rdata),
        .button_i    (button),
        .mti_o       (mti),
        .mei_o       (mei)
    );

    platform_checker u_chk (
        .clk         (clk),
        .reset_i     (reset_i),
        .bus_en_i    (bus_en),
        .bus_we_i    (bus_we),
        .bus_addr_i  (bus_addr),
        .bus_wdata_i (bus_wdata),
        .bus_rdata_i (bus_rdata)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    ////////////////////
    // bus tasks
    ////////////////////
    task automatic bus_write(input logic [31:0] addr, input logic [3:0] be,
                             input logic [31:0] data);
        @(posedge clk);
        bus_en    <= 1'b1;
        bus_we    <= be;
        bus_addr  <= addr;
        bus_wdata <= data;
        @(posedge clk);
        bus_en    <= 1'b0;
        bus_we    <= '0;
    endtask

    task automatic bus_read(input logic [31:0] addr, output logic [31:0] data);
        @(posedge clk);
        last_rd_cyc = cyc;
        bus_en   <= 1'b1;
        bus_we   <= '0;
        bus_addr <= addr;
        @(posedge clk);
        bus_en   <= 1'b0;
        @(negedge clk);
        data = bus_rdata;
    endtask

    task automatic wait_mei(input logic level, input string what);
        int n;
        n = 0;
        @(negedge clk);
        while (mei !== level && n < 50) begin
            @(negedge clk);
            n++;
        end
        if (mei !== level) begin
            u_chk.report_problem({"timeout, mei_o did not ", what});
        end
    endtask

    task automatic hold_mei_low(input int cycles, input string what);
        repeat (cycles) begin
            @(negedge clk);
            u_chk.check_value(what, {31'b0, mei}, 32'd0);
        end
    endtask

    task automatic test_done(input string name);
        $display("test %s finished with %0d errors", name, u_chk.error_cnt - err_mark);
        err_mark = u_chk.error_cnt;
    endtask

    // watchdog for the whole run
    initial begin
        #2000000;
        $display("simulation ran too long and was stopped");
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        logic [31:0] rd_addr [7];
        logic [31:0] rd_exp [7];
        logic [31:0] got [7];
        logic [31:0] r;
        logic [31:0] t1;
        logic [31:0] t2;
        logic [31:0] target;
        longint      mnow;
        int          c1;
        int          k;
        int          off;
        int          writes;

        clk       = 1'b0;
        reset_i   = 1'b1;
        bus_en    = 1'b0;
        bus_we    = '0;
        bus_addr  = '0;
        bus_wdata = '0;
        button    = '0;
        err_mark  = 0;
        repeat (2) @(posedge clk);
        reset_i <= 1'b0;

        //////////////////// ram byte enables
        for (int i = 0; i < RAM_WORDS; i++) begin
            bus_write(32'(i) << 2, 4'hF, lcg_next());
        end
        writes = 0;
        while (writes < 200) begin
            r = lcg_next();
            @(posedge clk);
            bus_en   <= 1'b1;
            bus_addr <= {3'b000, r[31], 18'h0, r[9:2], 2'b00};  // nibble 0 or 1
            if (r[12:10] < 3'd3) begin
                bus_we <= '0;
            end else begin
                bus_we    <= (r[16:13] == 4'h0) ? 4'hF : r[16:13];
                bus_wdata <= lcg_next();
                writes++;
            end
        end
        @(posedge clk);
        bus_en <= 1'b0;
        bus_we <= '0;
        repeat (2) @(negedge clk);
        test_done("ram byte enables");

        //////////////////// region decode, back-to-back reads
        bus_write(32'h1000_0010, 4'hF, 32'hA5C3_1E77);
        bus_write(32'h7000_0004, 4'hF, 32'h0000_0002);
        rd_addr = '{32'h1000_0010, 32'h9000_0000, 32'h3000_0004, 32'h0000_0010,
                    32'h2000_000C, 32'h7000_0004, 32'h8000_0000};
        rd_exp  = '{32'hA5C3_1E77, 32'h0, 32'h2, 32'hA5C3_1E77,
                    32'hFFFF_FFFF, 32'h2, 32'h0};
        for (int i = 0; i <= 7; i++) begin
            @(posedge clk);
            if (i < 7) begin
                bus_en   <= 1'b1;
                bus_we   <= '0;
                bus_addr <= rd_addr[i];
            end else begin
                bus_en <= 1'b0;
            end
            if (i > 0) begin
                @(negedge clk);
                got[i-1] = bus_rdata;
            end
        end
        for (int i = 0; i < 7; i++) begin
            u_chk.check_value("region read", got[i], rd_exp[i]);
        end
        bus_write(32'h3000_0004, 4'hF, 32'h0);
        test_done("region decode");

        //////////////////// rtc counting
        k = int'(lcg_next() % 32'd40) + 1;
        bus_read(32'h2000_0000, t1);
        c1 = last_rd_cyc;
        repeat (k) @(posedge clk);
        bus_read(32'h2000_0000, t2);
        u_chk.check_value("mtime delta", t2 - t1, 32'(last_rd_cyc - c1));
        test_done("rtc counting");

        //////////////////// timer interrupt
        off = 20 + int'(lcg_next() % 32'd81);
        bus_write(32'h2000_000C, 4'hF, 32'h0);
        bus_read(32'h2000_0000, t1);
        c1 = last_rd_cyc;
        target = t1 + 32'(off);
        bus_write(32'h2000_0008, 4'hF, target);
        for (int n = 0; n < off + 40; n++) begin
            @(negedge clk);
            mnow = longint'(t1) + longint'(cyc) - longint'(c1) - 1;
            // mti_o reflects the compare of the previous cycle
            u_chk.check_value("mti_o", {31'b0, mti},
                              {31'b0, (mnow - 1 >= longint'(target))});
        end
        test_done("timer interrupt");

        //////////////////// external interrupt path
        bus_write(32'h3000_0004, 4'hF, 32'h1);
        @(posedge clk);
        button <= 2'b01;
        wait_mei(1'b1, "rise after the first press");
        @(posedge clk);
        button <= 2'b00;
        bus_read(32'h9000_0000, r);
        u_chk.check_value("request bits before claim", r & 32'hC, 32'h4);
        bus_read(32'h3000_0008, r);
        u_chk.check_value("first claim id", r, 32'd1);
        wait_mei(1'b0, "fall after the claim");
        bus_read(32'h8000_0000, r);
        u_chk.check_value("request bits after claim", r & 32'hC, 32'h0);
        repeat (4) @(posedge clk);
        button <= 2'b01;
        hold_mei_low(12, "mei_o while in service");
        bus_write(32'h3000_0008, 4'hF, 32'd1);
        wait_mei(1'b1, "rise after the complete");
        @(posedge clk);
        button <= 2'b00;
        bus_read(32'h3000_0008, r);
        u_chk.check_value("second claim id", r, 32'd1);
        bus_write(32'h3000_0008, 4'hF, 32'd1);
        test_done("external interrupt");

        //////////////////// enable mask and claim order
        @(posedge clk);
        button <= 2'b10;
        hold_mei_low(12, "mei_o with source 2 masked");
        @(posedge clk);
        button <= 2'b00;
        bus_write(32'h3000_0004, 4'hF, 32'h3);
        wait_mei(1'b1, "rise once source 2 is enabled");   // pending kept while masked
        repeat (4) @(posedge clk);
        button <= 2'b11;
        repeat (6) @(posedge clk);
        bus_read(32'h3000_0008, r);
        u_chk.check_value("claim order 1", r, 32'd1);
        bus_read(32'h3000_0008, r);
        u_chk.check_value("claim order 2", r, 32'd2);
        bus_read(32'h3000_0008, r);
        u_chk.check_value("claim order empty", r, 32'd0);
        @(posedge clk);
        button <= 2'b00;
        bus_write(32'h3000_0008, 4'hF, 32'd1);
        bus_write(32'h3000_0008, 4'hF, 32'd2);
        test_done("enable mask and ordering");

        $display("tests 6, checks %0d, errors %0d", u_chk.check_cnt, u_chk.error_cnt);
        if (u_chk.error_cnt == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- platform_checker.sv
`timescale 1ns/1ns

module platform_checker
    import platform_pkg::*;
(
    input  logic              clk,
    input  logic              reset_i,
    input  logic              bus_en_i,
    input  logic [BE_W-1:0]   bus_we_i,
    input  logic [ADDR_W-1:0] bus_addr_i,
    input  logic [DATA_W-1:0] bus_wdata_i,
    input  logic [DATA_W-1:0] bus_rdata_i
);
    logic [7:0]        ram_model [RAM_WORDS*BE_W];   // byte image of the data ram
    logic              exp_pend = 1'b0;               // ram read data due now
    logic [DATA_W-1:0] exp_data;
    int                word;
    int                error_cnt = 0;
    int                check_cnt = 0;

    // compare one value, report a mismatch right away
    task automatic check_value(input string what, input logic [DATA_W-1:0] got,
                               input logic [DATA_W-1:0] exp);
        check_cnt++;
        if (got !== exp) begin
            error_cnt++;
            $display("Fail %0t: %s, got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic report_problem(input string msg);
        error_cnt++;
        $display("at %0t: %s", $time, msg);
    endtask

    ////////////////////
    // ram model, sampled mid-cycle
    ////////////////////
    always @(negedge clk) begin
        if (exp_pend) begin
            check_value("ram read data", bus_rdata_i, exp_data);
        end
        exp_pend = 1'b0;
        if (!reset_i && bus_en_i && (bus_addr_i[31:28] < 4'h2)) begin
            word = int'(bus_addr_i[9:2]);
            if (bus_we_i == '0) begin
                exp_pend = 1'b1;    // data shows up one cycle later
                for (int b = 0; b < BE_W; b++) begin
                    exp_data[8*b +: 8] = ram_model[word*BE_W + b];
                end
            end else begin
                for (int b = 0; b < BE_W; b++) begin
                    if (bus_we_i[b]) begin
                        ram_model[word*BE_W + b] = bus_wdata_i[8*b +: 8];
                    end
                end
            end
        end
    end

endmodule

//--- rv_platform.sv
`timescale 1ns/1ns

module rv_platform
    import platform_pkg::*;
(
    input  logic               clk,
    input  logic               reset_i,
    input  logic               bus_en_i,
    input  logic [BE_W-1:0]    bus_we_i,
    input  logic [ADDR_W-1:0]  bus_addr_i,
    input  logic [DATA_W-1:0]  bus_wdata_i,
    output logic [DATA_W-1:0]  bus_rdata_o,
    input  logic [IRQ_CNT-1:0] button_i,
    output logic               mti_o,
    output logic               mei_o
);
    logic [DATA_W-1:0]  ram_rdata;
    logic [DATA_W-1:0]  rtc_rdata;
    logic [DATA_W-1:0]  plic_rdata;
    logic [DATA_W-1:0]  per_rdata;
    logic [IRQ_CNT-1:0] btn_irq;
    logic [IRQ_CNT-1:0] btn_iack;

    mem_bus_if ram_bus ();
    mem_bus_if rtc_bus ();
    mem_bus_if plic_bus ();
    mem_bus_if per_bus ();

    ////////////////////
    // address decode
    ////////////////////
    bus_decoder u_decoder (
        .clk          (clk),
        .reset_i      (reset_i),
        .bus_en_i     (bus_en_i),
        .bus_we_i     (bus_we_i),
        .bus_addr_i   (bus_addr_i),
        .bus_wdata_i  (bus_wdata_i),
        .ram_bus      (ram_bus),
        .rtc_bus      (rtc_bus),
        .plic_bus     (plic_bus),
        .per_bus      (per_bus),
        .ram_rdata_i  (ram_rdata),
        .rtc_rdata_i  (rtc_rdata),
        .plic_rdata_i (plic_rdata),
        .per_rdata_i  (per_rdata),
        .bus_rdata_o  (bus_rdata_o)
    );

    ////////////////////
    // slaves
    ////////////////////
    data_ram u_ram (
        .clk     (clk),
        .bus     (ram_bus),
        .rdata_o (ram_rdata)
    );

    rtc_timer u_rtc (
        .clk     (clk),
        .reset_i (reset_i),
        .bus     (rtc_bus),
        .rdata_o (rtc_rdata),
        .mti_o   (mti_o)
    );

    plic u_plic (
        .clk     (clk),
        .reset_i (reset_i),
        .bus     (plic_bus),
        .rdata_o (plic_rdata),
        .irq_i   (btn_irq),
        .iack_o  (btn_iack),     // per-source ack on claim
        .mei_o   (mei_o)
    );

    button_periph u_buttons (
        .clk      (clk),
        .reset_i  (reset_i),
        .bus      (per_bus),
        .rdata_o  (per_rdata),
        .button_i (button_i),
        .irq_o    (btn_irq),
        .iack_i   (btn_iack)
    );

endmodule

//--- button_periph.sv
`timescale 1ns/1ns

module button_periph
    import platform_pkg::*;
(
    input  logic               clk,
    input  logic               reset_i,
    mem_bus_if.slave           bus,
    output logic [DATA_W-1:0]  rdata_o,
    input  logic [IRQ_CNT-1:0] button_i,
    output logic [IRQ_CNT-1:0] irq_o,
    input  logic [IRQ_CNT-1:0] iack_i
);
    logic [IRQ_CNT-1:0] btn_s1;     // first sync stage
    logic [IRQ_CNT-1:0] btn_s2;     // synchronized level
    logic [IRQ_CNT-1:0] btn_q;      // previous level, for edges
    logic [IRQ_CNT-1:0] press;

    ////////////////////
    // synchronizer and edge detect
    ////////////////////
    always_ff @(posedge clk) begin
        if (reset_i) begin
            btn_s1 <= '0;
            btn_s2 <= '0;
            btn_q  <= '0;
        end else begin
            btn_s1 <= button_i;
            btn_s2 <= btn_s1;
            btn_q  <= btn_s2;
        end
    end

    assign press = btn_s2 & ~btn_q;

    // request held until the plic acknowledges it
    always_ff @(posedge clk) begin
        if (reset_i) begin
            irq_o <= '0;
        end else begin
            irq_o <= (irq_o & ~iack_i) | press;
        end
    end

    // status register
    always_ff @(posedge clk) begin
        if (bus.en) begin
            if (bus.addr[3:0] == BTN_STATUS) begin
                rdata_o <= DATA_W'({irq_o, btn_s2});
            end else begin
                rdata_o <= '0;
            end
        end
    end

endmodule

//--- plic.sv
`timescale 1ns/1ns

module plic
    import platform_pkg::*;
(
    input  logic               clk,
    input  logic               reset_i,
    mem_bus_if.slave           bus,
    output logic [DATA_W-1:0]  rdata_o,
    input  logic [IRQ_CNT-1:0] irq_i,
    output logic [IRQ_CNT-1:0] iack_o,
    output logic               mei_o
);
    logic [IRQ_CNT-1:0]   pending;
    logic [IRQ_CNT-1:0]   enable;
    logic [IRQ_CNT-1:0]   in_service;

    logic [PLIC_ID_W-1:0] claim_id;     // 1-based, 0 when nothing to claim
    logic [IRQ_CNT-1:0]   claim_oh;
    logic                 rd_strobe;
    logic                 wr_strobe;
    logic                 claim_rd;
    logic                 claim_wr;

    assign rd_strobe = bus.en && (bus.we == '0);
    assign wr_strobe = bus.en && (bus.we != '0);
    assign claim_rd  = rd_strobe && (bus.addr[3:0] == PLIC_CLAIM);
    assign claim_wr  = wr_strobe && (bus.addr[3:0] == PLIC_CLAIM);

    ////////////////////
    // claim arbitration
    ////////////////////
    always_comb begin
        claim_id = '0;
        claim_oh = '0;
        // walk down so the lowest source wins
        for (int i = IRQ_CNT - 1; i >= 0; i--) begin
            if (pending[i] && enable[i]) begin
                claim_id    = PLIC_ID_W'(i + 1);
                claim_oh    = '0;
                claim_oh[i] = 1'b1;
            end
        end
    end

    ////////////////////
    // gateway state
    ////////////////////
    always_ff @(posedge clk) begin
        if (reset_i) begin
            pending    <= '0;
            enable     <= '0;
            in_service <= '0;
            iack_o     <= '0;
        end else begin
            // sources in service are masked off
            pending <= (pending | (irq_i & ~in_service)) & ~(claim_rd ? claim_oh : '0);
            iack_o  <= claim_rd ? claim_oh : '0;

            if (claim_rd) begin
                in_service <= in_service | claim_oh;
            end else if (claim_wr) begin
                for (int i = 0; i < IRQ_CNT; i++) begin
                    if (bus.wdata == DATA_W'(i + 1)) begin
                        in_service[i] <= 1'b0;  // complete
                    end
                end
            end

            if (wr_strobe && (bus.addr[3:0] == PLIC_ENABLE)) begin
                enable <= bus.wdata[IRQ_CNT-1:0];
            end
        end
    end

    // read data, claim id from before the update
    always_ff @(posedge clk) begin
        if (bus.en) begin
            case (bus.addr[3:0])
                PLIC_PENDING: rdata_o <= DATA_W'(pending);
                PLIC_ENABLE:  rdata_o <= DATA_W'(enable);
                PLIC_CLAIM:   rdata_o <= DATA_W'(claim_id);
                default:      rdata_o <= '0;
            endcase
        end
    end

    // external interrupt to the core
    always_ff @(posedge clk) begin
        if (reset_i) begin
            mei_o <= 1'b0;
        end else begin
            mei_o <= |(pending & enable & ~in_service);
        end
    end

endmodule

//--- rtc_timer.sv
`timescale 1ns/1ns

module rtc_timer
    import platform_pkg::*;
(
    input  logic              clk,
    input  logic              reset_i,
    mem_bus_if.slave          bus,
    output logic [DATA_W-1:0] rdata_o,
    output logic              mti_o
);
    logic [63:0] mtime;
    logic [63:0] mtimecmp;
    logic        wr_strobe;

    assign wr_strobe = bus.en && (bus.we != '0);

    ////////////////////
    // free-running time base
    ////////////////////
    always_ff @(posedge clk) begin
        if (reset_i) begin
            mtime <= '0;
        end else begin
            mtime <= mtime + 64'd1;
        end
    end

    // compare value, written one half at a time
    always_ff @(posedge clk) begin
        if (reset_i) begin
            mtimecmp <= '1;     // no interrupt out of reset
        end else if (wr_strobe) begin
            case (bus.addr[3:0])
                RTC_CMP_LO: mtimecmp[31:0]  <= bus.wdata;
                RTC_CMP_HI: mtimecmp[63:32] <= bus.wdata;
                default: ;      // mtime is read only
            endcase
        end
    end

    // register read, value of the strobe cycle
    always_ff @(posedge clk) begin
        if (bus.en) begin
            case (bus.addr[3:0])
                RTC_MTIME_LO: rdata_o <= mtime[31:0];
                RTC_MTIME_HI: rdata_o <= mtime[63:32];
                RTC_CMP_LO:   rdata_o <= mtimecmp[31:0];
                RTC_CMP_HI:   rdata_o <= mtimecmp[63:32];
                default:      rdata_o <= '0;
            endcase
        end
    end

    ////////////////////
    // timer interrupt
    ////////////////////
    always_ff @(posedge clk) begin
        if (reset_i) begin
            mti_o <= 1'b0;
        end else begin
            mti_o <= (mtime >= mtimecmp);
        end
    end

endmodule

//--- data_ram.sv
`timescale 1ns/1ns

module data_ram
    import platform_pkg::*;
(
    input  logic              clk,
    mem_bus_if.slave          bus,
    output logic [DATA_W-1:0] rdata_o
);
    logic [DATA_W-1:0] mem [RAM_WORDS];
    logic [RAM_AW-1:0] word_addr;

    assign word_addr = bus.addr[RAM_AW+1:2];    // bits 9:2

    // byte lane writes
    always_ff @(posedge clk) begin
        if (bus.en) begin
            for (int b = 0; b < BE_W; b++) begin
                if (bus.we[b]) begin
                    mem[word_addr][8*b +: 8] <= bus.wdata[8*b +: 8];
                end
            end
        end
    end

    // registered read, old word on a write strobe
    always_ff @(posedge clk) begin
        if (bus.en) begin
            rdata_o <= mem[word_addr];
        end
    end

endmodule

//--- bus_decoder.sv
`timescale 1ns/1ns

module bus_decoder
    import platform_pkg::*;
(
    input  logic              clk,
    input  logic              reset_i,
    input  logic              bus_en_i,
    input  logic [BE_W-1:0]   bus_we_i,
    input  logic [ADDR_W-1:0] bus_addr_i,
    input  logic [DATA_W-1:0] bus_wdata_i,
    mem_bus_if.master         ram_bus,
    mem_bus_if.master         rtc_bus,
    mem_bus_if.master         plic_bus,
    mem_bus_if.master         per_bus,
    input  logic [DATA_W-1:0] ram_rdata_i,
    input  logic [DATA_W-1:0] rtc_rdata_i,
    input  logic [DATA_W-1:0] plic_rdata_i,
    input  logic [DATA_W-1:0] per_rdata_i,
    output logic [DATA_W-1:0] bus_rdata_o
);
    region_e region;
    region_e rd_sel;      // region of the last read strobe
    logic    rd_pend;     // read data due this cycle
    logic    rd_strobe;

    ////////////////////
    // region decode
    ////////////////////
    always_comb begin
        if (bus_addr_i[31:28] < 4'h2) begin
            region = REG_RAM;
        end else if (bus_addr_i[31:28] < 4'h3) begin
            region = REG_RTC;
        end else if (bus_addr_i[31:28] < 4'h8) begin
            region = REG_PLIC;
        end else begin
            region = REG_PERIPH;
        end
    end

    // same access fanned out, strobe only to the selected slave
    assign ram_bus.en     = bus_en_i && (region == REG_RAM);
    assign ram_bus.we     = bus_we_i;
    assign ram_bus.addr   = bus_addr_i;
    assign ram_bus.wdata  = bus_wdata_i;

    assign rtc_bus.en     = bus_en_i && (region == REG_RTC);
    assign rtc_bus.we     = bus_we_i;
    assign rtc_bus.addr   = bus_addr_i;
    assign rtc_bus.wdata  = bus_wdata_i;

    assign plic_bus.en    = bus_en_i && (region == REG_PLIC);
    assign plic_bus.we    = bus_we_i;
    assign plic_bus.addr  = bus_addr_i;
    assign plic_bus.wdata = bus_wdata_i;

    assign per_bus.en     = bus_en_i && (region == REG_PERIPH);
    assign per_bus.we     = bus_we_i;
    assign per_bus.addr   = bus_addr_i;
    assign per_bus.wdata  = bus_wdata_i;

    ////////////////////
    // read data select
    ////////////////////
    assign rd_strobe = bus_en_i && (bus_we_i == '0);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            rd_sel  <= REG_RAM;
            rd_pend <= 1'b0;
        end else begin
            rd_pend <= rd_strobe;
            if (rd_strobe) begin
                rd_sel <= region;   // held between reads
            end
        end
    end

    always_comb begin
        bus_rdata_o = ram_rdata_i;  // idle default
        if (rd_pend) begin
            case (rd_sel)
                REG_RTC:    bus_rdata_o = rtc_rdata_i;
                REG_PLIC:   bus_rdata_o = plic_rdata_i;
                REG_PERIPH: bus_rdata_o = per_rdata_i;
                default:    bus_rdata_o = ram_rdata_i;
            endcase
        end
    end

endmodule

//--- mem_bus_if.sv
`timescale 1ns/1ns

// one data bus access, decoder to a single slave
interface mem_bus_if
    import platform_pkg::*;
();
    logic              en;      // single-cycle strobe
    logic [BE_W-1:0]   we;      // byte enables, zero on a read
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;

    modport master (
        output en,
        output we,
        output addr,
        output wdata
    );

    modport slave (
        input  en,
        input  we,
        input  addr,
        input  wdata
    );

endinterface

//--- platform_pkg.sv
package platform_pkg;

    ////////////////////
    // bus geometry
    ////////////////////
    localparam int ADDR_W    = 32;
    localparam int DATA_W    = 32;
    localparam int BE_W      = 4;

    // data ram
    localparam int RAM_WORDS = 256;
    localparam int RAM_AW    = $clog2(RAM_WORDS);   // word address bits

    // interrupt sources, one per button
    localparam int IRQ_CNT   = 2;
    localparam int PLIC_ID_W = $clog2(IRQ_CNT + 1); // ids 0..IRQ_CNT

    // region picked by the top address nibble
    typedef enum logic [1:0] {
        REG_RAM    = 2'd0,
        REG_RTC    = 2'd1,
        REG_PLIC   = 2'd2,
        REG_PERIPH = 2'd3
    } region_e;

    ////////////////////
    // register offsets, byte address bits 3:0
    ////////////////////
    localparam logic [3:0] RTC_MTIME_LO = 4'h0;
    localparam logic [3:0] RTC_MTIME_HI = 4'h4;
    localparam logic [3:0] RTC_CMP_LO   = 4'h8;
    localparam logic [3:0] RTC_CMP_HI   = 4'hC;

    localparam logic [3:0] PLIC_PENDING = 4'h0;
    localparam logic [3:0] PLIC_ENABLE  = 4'h4;
    localparam logic [3:0] PLIC_CLAIM   = 4'h8;

    localparam logic [3:0] BTN_STATUS   = 4'h0;

endpackage
